/* hw/cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// datapath widths
`define CPU_DATA_W      8               // register and memory byte width
`define CPU_PC_W        32              // program counter width
`define CPU_REG_ADDR_W  3               // register index width
`define CPU_NUM_REGS    8               // size of the register file
`define CPU_PC_STEP     4               // bytes per instruction word

// opcodes, bits 31..24 of the instruction word
`define OP_LOADI        8'h00           // rd = imm
`define OP_MOV          8'h01           // rd = rs2
`define OP_ADD          8'h02           // rd = rs1 + rs2
`define OP_SUB          8'h03           // rd = rs1 - rs2
`define OP_AND          8'h04           // rd = rs1 & rs2
`define OP_OR           8'h05           // rd = rs1 | rs2
`define OP_J            8'h06           // unconditional relative jump
`define OP_BEQ          8'h07           // branch if rs1 == rs2
`define OP_BNE          8'h0D           // branch if rs1 != rs2
`define OP_LWD          8'h0E           // rd = mem[rs2]
`define OP_LWI          8'h0F           // rd = mem[imm]
`define OP_SWD          8'h10           // mem[rs2] = rs1
`define OP_SWI          8'h11           // mem[imm] = rs1

// alu operation codes
`define ALU_FWD         2'b00           // pass operand b through
`define ALU_ADD         2'b01           // a + b, also used for sub and compare
`define ALU_AND         2'b10           // bitwise and
`define ALU_OR          2'b11           // bitwise or

`endif

/* hw/isa_pkg.sv */
`include "cpu_cfg.svh"

package isa_pkg;

    // register form, used by alu, load and store instructions
    typedef struct packed {
        logic [7:0]                     opcode;     // bits 31..24
        logic [4:0]                     rsvd_hi;    // bits 23..19, ignored
        logic [`CPU_REG_ADDR_W-1:0]     dest;       // bits 18..16
        logic [4:0]                     rsvd_mid;   // bits 15..11, ignored
        logic [`CPU_REG_ADDR_W-1:0]     src1;       // bits 10..8
        logic [`CPU_DATA_W-1:0]         imm;        // bits 7..0, low 3 bits are src2
    } reg_form_t;

    // branch form, used by j, beq and bne
    typedef struct packed {
        logic [7:0]                     opcode;     // bits 31..24
        logic signed [7:0]              offset;     // word offset from pc + 4
        logic [4:0]                     rsvd_mid;   // bits 15..11, ignored
        logic [`CPU_REG_ADDR_W-1:0]     src1;       // bits 10..8
        logic [4:0]                     rsvd_lo;    // bits 7..3, ignored
        logic [`CPU_REG_ADDR_W-1:0]     src2;       // bits 2..0
    } branch_form_t;

    // one 32-bit word, two ways of reading it
    typedef union packed {
        reg_form_t      reg_form;
        branch_form_t   branch_form;
    } instr_word_t;

endpackage

/* hw/instr_decoder.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module instr_decoder import isa_pkg::*;
(
    input  instr_word_t  instr,         // instruction currently presented
    input  logic         busywait,      // memory still working
    output logic         reg_write,     // register write enable, stall gated
    output logic         use_imm,       // operand b from immediate
    output logic         negate_b,      // two's complement of operand b
    output logic [1:0]   alu_op,        // alu operation select
    output logic         branch,        // conditional branch
    output logic         branch_on_ne,  // branch sense, 1 for bne
    output logic         jump,          // unconditional jump
    output logic         read,          // memory read strobe, level
    output logic         write,         // memory write strobe, level
    output logic         load_sel       // write back from read_data
);

    logic write_en;                     // raw write enable before stall gating

    always_comb
    begin
        write_en     = 1'b0;            // unknown opcodes fall through as no-ops
        use_imm      = 1'b0;
        negate_b     = 1'b0;
        alu_op       = `ALU_FWD;
        branch       = 1'b0;
        branch_on_ne = 1'b0;
        jump         = 1'b0;
        read         = 1'b0;
        write        = 1'b0;
        load_sel     = 1'b0;
        case (instr.reg_form.opcode)
            `OP_LOADI:
            begin
                write_en = 1'b1;
                use_imm  = 1'b1;        // forward the immediate
            end
            `OP_MOV:   write_en = 1'b1; // forward rs2
            `OP_ADD:
            begin
                write_en = 1'b1;
                alu_op   = `ALU_ADD;
            end
            `OP_SUB:
            begin
                write_en = 1'b1;
                alu_op   = `ALU_ADD;
                negate_b = 1'b1;        // a + (-b)
            end
            `OP_AND:
            begin
                write_en = 1'b1;
                alu_op   = `ALU_AND;
            end
            `OP_OR:
            begin
                write_en = 1'b1;
                alu_op   = `ALU_OR;
            end
            `OP_J:     jump = 1'b1;
            `OP_BEQ, `OP_BNE:
            begin
                branch       = 1'b1;
                alu_op       = `ALU_ADD; // compare by subtraction, zero flag decides
                negate_b     = 1'b1;
                branch_on_ne = (instr.reg_form.opcode == `OP_BNE);
            end
            `OP_LWD, `OP_LWI:
            begin
                write_en = 1'b1;
                use_imm  = (instr.reg_form.opcode == `OP_LWI); // address from imm
                read     = 1'b1;
                load_sel = 1'b1;
            end
            `OP_SWD, `OP_SWI:
            begin
                use_imm = (instr.reg_form.opcode == `OP_SWI);
                write   = 1'b1;         // data is rs1, memory latches it itself
            end
            default:   write_en = 1'b0;
        endcase
    end

    assign reg_write = write_en & ~busywait;  // stalled load must not write yet

endmodule

/* hw/register_file.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module register_file import isa_pkg::*;
(
    input  logic                    CLK,
    input  logic                    rst_n,
    input  instr_word_t             instr,      // register indices come from here
    input  logic                    reg_write,  // write dest on this edge
    input  logic [`CPU_DATA_W-1:0]  wb_data,    // value to write back
    output logic [`CPU_DATA_W-1:0]  operand_a,  // contents of src1
    output logic [`CPU_DATA_W-1:0]  operand_b   // contents of src2
);

    logic [`CPU_DATA_W-1:0]     regs [`CPU_NUM_REGS];   // general purpose registers
    logic [`CPU_REG_ADDR_W-1:0] src1_idx;               // first read index
    logic [`CPU_REG_ADDR_W-1:0] src2_idx;               // second read index
    logic [`CPU_REG_ADDR_W-1:0] dest_idx;               // write index

    assign src1_idx = instr.reg_form.src1;
    assign src2_idx = instr.reg_form.imm[`CPU_REG_ADDR_W-1:0]; // shares bits with imm
    assign dest_idx = instr.reg_form.dest;

    // asynchronous reads
    assign operand_a = regs[src1_idx];
    assign operand_b = regs[src2_idx];

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `CPU_NUM_REGS; i++)
            begin
                regs[i] <= '0;          // all registers start at zero
            end
        end
        else if (reg_write)
        begin
            regs[dest_idx] <= wb_data;
        end
    end

endmodule

/* hw/exec_unit.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module exec_unit import isa_pkg::*;
(
    input  instr_word_t             instr,      // immediate source
    input  logic [`CPU_DATA_W-1:0]  operand_a,  // rs1 value
    input  logic [`CPU_DATA_W-1:0]  operand_b,  // rs2 value
    input  logic                    use_imm,    // take immediate instead of rs2
    input  logic                    negate_b,   // negate the selected operand
    input  logic [1:0]              alu_op,     // operation select
    input  logic                    load_sel,   // write back memory data
    input  logic [`CPU_DATA_W-1:0]  read_data,  // byte from data memory
    output logic [`CPU_DATA_W-1:0]  alu_result, // also the memory address
    output logic                    zero,       // result is all zero
    output logic [`CPU_DATA_W-1:0]  wb_data     // value for the register file
);

    logic [`CPU_DATA_W-1:0] b_sel;      // immediate or rs2
    logic [`CPU_DATA_W-1:0] b_val;      // after optional negation

    assign b_sel = use_imm ? instr.reg_form.imm : operand_b;
    assign b_val = negate_b ? (-b_sel) : b_sel;  // two's complement

    always_comb
    begin
        case (alu_op)
            `ALU_FWD: alu_result = b_val;
            `ALU_ADD: alu_result = operand_a + b_val;   // wraps at 8 bits
            `ALU_AND: alu_result = operand_a & b_val;
            `ALU_OR:  alu_result = operand_a | b_val;
            default:  alu_result = b_val;
        endcase
    end

    // beq/bne look at this after rs1 - rs2
    assign zero = (alu_result == '0);

    // loads take the memory byte, everything else the alu
    assign wb_data = load_sel ? read_data : alu_result;

endmodule

/* hw/pc_unit.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module pc_unit import isa_pkg::*;
(
    input  logic                    CLK,
    input  logic                    rst_n,
    input  logic                    busywait,       // stall, hold pc
    input  instr_word_t             instr,          // branch offset source
    input  logic                    branch,         // conditional branch
    input  logic                    branch_on_ne,   // 1 takes on not equal
    input  logic                    jump,           // always take the target
    input  logic                    zero,           // compare result from alu
    output logic [`CPU_PC_W-1:0]    pc              // address of current instruction
);

    logic [`CPU_DATA_W-1:0] offset;     // signed word offset from instruction
    logic [`CPU_PC_W-1:0]   offset_ext; // sign extended to pc width
    logic [`CPU_PC_W-1:0]   pc_seq;     // next sequential pc
    logic [`CPU_PC_W-1:0]   pc_target;  // branch or jump destination
    logic                   take;       // redirect this cycle

    assign offset     = instr.branch_form.offset;
    assign offset_ext = {{(`CPU_PC_W - `CPU_DATA_W){offset[`CPU_DATA_W-1]}}, offset};

    assign pc_seq    = pc + `CPU_PC_STEP;
    // offset counts words, relative to pc + 4
    assign pc_target = pc_seq + (offset_ext << $clog2(`CPU_PC_STEP));

    // beq takes on zero, bne on not zero
    assign take = jump | (branch & (zero ^ branch_on_ne));

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc <= '0;
        end
        else if (!busywait)             // memory access retires on this edge
        begin
            pc <= take ? pc_target : pc_seq;
        end
    end

endmodule

/* hw/cpu_core.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module cpu_core import isa_pkg::*;
(
    input  logic                    CLK,
    input  logic                    rst_n,
    input  instr_word_t             instr,      // instruction at pc
    input  logic [`CPU_DATA_W-1:0]  read_data,  // load data from memory
    input  logic                    busywait,   // memory stall
    output logic [`CPU_PC_W-1:0]    pc,         // instruction fetch address
    output logic                    read,       // load strobe
    output logic                    write,      // store strobe
    output logic [`CPU_DATA_W-1:0]  address,    // data memory address
    output logic [`CPU_DATA_W-1:0]  write_data  // store data
);

    logic                   reg_write;
    logic                   use_imm;
    logic                   negate_b;
    logic [1:0]             alu_op;
    logic                   branch;
    logic                   branch_on_ne;
    logic                   jump;
    logic                   load_sel;
    logic [`CPU_DATA_W-1:0] operand_a;      // rs1, also store data
    logic [`CPU_DATA_W-1:0] operand_b;      // rs2
    logic [`CPU_DATA_W-1:0] alu_result;     // also memory address
    logic [`CPU_DATA_W-1:0] wb_data;
    logic                   zero;

    instr_decoder u_decoder (
        .instr(instr), .busywait(busywait), .reg_write(reg_write),
        .use_imm(use_imm), .negate_b(negate_b), .alu_op(alu_op),
        .branch(branch), .branch_on_ne(branch_on_ne), .jump(jump),
        .read(read), .write(write), .load_sel(load_sel)
    );

    register_file u_regs (
        .CLK(CLK), .rst_n(rst_n), .instr(instr), .reg_write(reg_write),
        .wb_data(wb_data), .operand_a(operand_a), .operand_b(operand_b)
    );

    exec_unit u_exec (
        .instr(instr), .operand_a(operand_a), .operand_b(operand_b),
        .use_imm(use_imm), .negate_b(negate_b), .alu_op(alu_op),
        .load_sel(load_sel), .read_data(read_data), .alu_result(alu_result),
        .zero(zero), .wb_data(wb_data)
    );

    pc_unit u_pc (
        .CLK(CLK), .rst_n(rst_n), .busywait(busywait), .instr(instr),
        .branch(branch), .branch_on_ne(branch_on_ne), .jump(jump),
        .zero(zero), .pc(pc)
    );

    assign write_data = operand_a;      // swd/swi store rs1
    assign address    = alu_result;     // rs2 or imm forwarded by the alu

endmodule

/* tests/cpu_core_tb.sv */
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module cpu_core_tb import isa_pkg::*; ();

    logic                   CLK;
    logic                   rst_n;
    instr_word_t            instr;
    logic [`CPU_DATA_W-1:0] read_data;
    logic                   busywait;
    logic [`CPU_PC_W-1:0]   pc;
    logic                   read;
    logic                   write;
    logic [`CPU_DATA_W-1:0] address;
    logic [`CPU_DATA_W-1:0] write_data;

    string                  row_name [$];       // one entry per executed instruction
    logic [31:0]            row_word [$];
    logic [`CPU_PC_W-1:0]   row_pc [$];         // pc while the word is presented
    logic                   row_store [$];      // row must show a store
    logic [`CPU_DATA_W-1:0] row_addr [$];
    logic [`CPU_DATA_W-1:0] row_data [$];

    logic [`CPU_DATA_W-1:0] mem [256];          // data memory contents
    logic                   mem_ready = 1'b0;   // next edge retires the access
    logic [`CPU_DATA_W-1:0] rd_byte = '0;
    int unsigned            busy_left = 0;      // stall edges still to come
    int unsigned            access_count = 0;   // accesses actually performed
    int unsigned            draw;
    int unsigned            cycles = 0;

    cpu_core uut (
        .CLK(CLK), .rst_n(rst_n), .instr(instr), .read_data(read_data),
        .busywait(busywait), .pc(pc), .read(read), .write(write),
        .address(address), .write_data(write_data)
    );

    initial
    begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;                 // 40 ns period
    end

    // memory busy as soon as a strobe shows up, until the model is ready
    assign busywait  = (read | write) & ~mem_ready;
    assign read_data = rd_byte;

    always @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mem_ready <= 1'b0;
            busy_left <= 0;
        end
        else if (mem_ready)                     // retiring edge, one access only
        begin
            mem_ready <= 1'b0;
            if (write)
                mem[address] = write_data;
            access_count <= access_count + 1;
        end
        else if (read || write)
        begin
            draw = (busy_left == 0) ? $urandom_range(3, 1) : busy_left; // 1..3 stall edges
            if (draw == 1)
            begin
                mem_ready <= 1'b1;
                busy_left <= 0;
                rd_byte   <= mem[address];      // load data valid for the retiring edge
            end
            else
                busy_left <= draw - 1;
        end
    end

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles >= row_name.size() * 5 + 20)
            abort_run("timeout: the core stopped making progress");
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_pc(input string name, input logic [`CPU_PC_W-1:0] exp_val,
                            input logic [`CPU_PC_W-1:0] act_val);
        if (act_val !== exp_val)
            abort_run($sformatf("FAIL %s: expected %0d, actual %0d", name, exp_val, act_val));
    endtask

    task automatic check_byte(input string name, input logic [`CPU_DATA_W-1:0] exp_val,
                              input logic [`CPU_DATA_W-1:0] act_val);
        if (act_val !== exp_val)
            abort_run($sformatf("FAIL %s: expected %h, actual %h", name, exp_val, act_val));
    endtask

    task automatic check_flag(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val)
            abort_run($sformatf("FAIL %s: expected %b, actual %b", name, exp_val, act_val));
    endtask

    // register form: op, dest, src1, imm (low 3 bits are src2)
    function automatic logic [31:0] enc_reg(input logic [7:0] op, input logic [2:0] rd,
                                            input logic [2:0] rs1, input logic [7:0] imm);
        return {op, 5'b0, rd, 5'b0, rs1, imm};
    endfunction

    function automatic logic [31:0] enc_branch(input logic [7:0] op, input logic [7:0] off,
                                               input logic [2:0] rs1, input logic [2:0] rs2);
        return {op, off, 5'b0, rs1, 5'b0, rs2};
    endfunction

    function automatic logic is_mem_op(input logic [7:0] op);
        return op inside {`OP_LWD, `OP_LWI, `OP_SWD, `OP_SWI};
    endfunction

    function automatic logic is_load(input logic [7:0] op);
        return op inside {`OP_LWD, `OP_LWI};
    endfunction

    task automatic add_row(input string name, input logic [31:0] word, input int pc_val,
                           input logic store, input logic [7:0] addr, input logic [7:0] data);
        row_name.push_back(name);
        row_word.push_back(word);
        row_pc.push_back(pc_val);
        row_store.push_back(store);
        row_addr.push_back(addr);
        row_data.push_back(data);
    endtask

    // r1 = 5A, r2 = C3, memory holds swapped nibbles ^ 3C
    task automatic load_program();
        add_row("loadi r1", enc_reg(`OP_LOADI, 3'd1, 3'd0, 8'h5A), 0, 1'b0, 8'h00, 8'h00);
        add_row("loadi r2", enc_reg(`OP_LOADI, 3'd2, 3'd0, 8'hC3), 4, 1'b0, 8'h00, 8'h00);
        add_row("add r3", enc_reg(`OP_ADD, 3'd3, 3'd1, 8'h02), 8, 1'b0, 8'h00, 8'h00);
        add_row("swi add", enc_reg(`OP_SWI, 3'd0, 3'd3, 8'h80), 12, 1'b1, 8'h80, 8'h1D);
        add_row("sub r4", enc_reg(`OP_SUB, 3'd4, 3'd1, 8'h02), 16, 1'b0, 8'h00, 8'h00);
        add_row("swi sub", enc_reg(`OP_SWI, 3'd0, 3'd4, 8'h81), 20, 1'b1, 8'h81, 8'h97);
        add_row("and r5", enc_reg(`OP_AND, 3'd5, 3'd1, 8'h02), 24, 1'b0, 8'h00, 8'h00);
        add_row("or r6", enc_reg(`OP_OR, 3'd6, 3'd1, 8'h02), 28, 1'b0, 8'h00, 8'h00);
        add_row("loadi r7", enc_reg(`OP_LOADI, 3'd7, 3'd0, 8'h82), 32, 1'b0, 8'h00, 8'h00);
        add_row("swd and", enc_reg(`OP_SWD, 3'd0, 3'd5, 8'h07), 36, 1'b1, 8'h82, 8'h42);
        add_row("mov r0", enc_reg(`OP_MOV, 3'd0, 3'd0, 8'h06), 40, 1'b0, 8'h00, 8'h00);
        add_row("swi mov", enc_reg(`OP_SWI, 3'd0, 3'd0, 8'h83), 44, 1'b1, 8'h83, 8'hDB);
        add_row("loadi r7 ptr", enc_reg(`OP_LOADI, 3'd7, 3'd0, 8'h20), 48, 1'b0, 8'h00, 8'h00);
        add_row("lwd r1", enc_reg(`OP_LWD, 3'd1, 3'd0, 8'h07), 52, 1'b0, 8'h00, 8'h00);
        add_row("lwi r2", enc_reg(`OP_LWI, 3'd2, 3'd0, 8'h47), 56, 1'b0, 8'h00, 8'h00);
        add_row("swi lwd", enc_reg(`OP_SWI, 3'd0, 3'd1, 8'h84), 60, 1'b1, 8'h84, 8'h3E);
        add_row("swi lwi", enc_reg(`OP_SWI, 3'd0, 3'd2, 8'h85), 64, 1'b1, 8'h85, 8'h48);
        add_row("beq taken", enc_branch(`OP_BEQ, 8'sd2, 3'd1, 3'd1), 68, 1'b0, 8'h00, 8'h00);
        add_row("bne taken", enc_branch(`OP_BNE, 8'sd1, 3'd1, 3'd2), 80, 1'b0, 8'h00, 8'h00);
        add_row("beq fall", enc_branch(`OP_BEQ, 8'sd5, 3'd1, 3'd2), 88, 1'b0, 8'h00, 8'h00);
        add_row("bne fall", enc_branch(`OP_BNE, 8'sd3, 3'd3, 3'd3), 92, 1'b0, 8'h00, 8'h00);
        add_row("j forward", enc_branch(`OP_J, 8'sd4, 3'd0, 3'd0), 96, 1'b0, 8'h00, 8'h00);
        add_row("j back", enc_branch(`OP_J, -8'sd3, 3'd0, 3'd0), 116, 1'b0, 8'h00, 8'h00);
        add_row("swi or", enc_reg(`OP_SWI, 3'd0, 3'd6, 8'h86), 108, 1'b1, 8'h86, 8'hDB);
        add_row("j skip", enc_branch(`OP_J, 8'sd2, 3'd0, 3'd0), 112, 1'b0, 8'h00, 8'h00);
        add_row("sub r0", enc_reg(`OP_SUB, 3'd0, 3'd2, 8'h01), 124, 1'b0, 8'h00, 8'h00);
        add_row("swd sub", enc_reg(`OP_SWD, 3'd0, 3'd0, 8'h07), 128, 1'b1, 8'h20, 8'h0A);
        add_row("lwi reload", enc_reg(`OP_LWI, 3'd3, 3'd0, 8'h20), 132, 1'b0, 8'h00, 8'h00);
        add_row("swi reload", enc_reg(`OP_SWI, 3'd0, 3'd3, 8'h88), 136, 1'b1, 8'h88, 8'h0A);
    endtask

    initial
    begin
        int unsigned exp_access;
        logic        stalled;
        rst_n      = 1'b0;
        instr      = '0;                        // loadi r0, 0 during reset
        exp_access = 0;
        void'($urandom(45706));
        for (int a = 0; a < 256; a++)
            mem[a] = {a[3:0], a[7:4]} ^ 8'h3C;
        load_program();
        repeat (5) @(posedge CLK);
        check_pc("reset pc", '0, pc);
        check_flag("reset read", 1'b0, read);
        check_flag("reset write", 1'b0, write);
        @(negedge CLK);
        rst_n = 1'b1;
        for (int i = 0; i < row_name.size(); i++)
        begin
            instr = row_word[i];
            do
            begin
                @(posedge CLK);                 // values still from before this edge
                check_pc(row_name[i], row_pc[i], pc);  // held through any stall
                // strobes are levels for the whole access, low otherwise
                check_flag({row_name[i], " read"}, is_load(row_word[i][31:24]), read);
                check_flag({row_name[i], " write"}, row_store[i], write);
                if (row_store[i])
                begin
                    check_byte({row_name[i], " address"}, row_addr[i], address);
                    check_byte({row_name[i], " data"}, row_data[i], write_data);
                end
                stalled = busywait;
            end
            while (stalled);
            @(negedge CLK);
        end
        check_pc("final pc", row_pc[row_pc.size() - 1] + 4, pc);
        foreach (row_word[i])
            if (is_mem_op(row_word[i][31:24]))
                exp_access++;
        if (access_count != exp_access)
            abort_run($sformatf("memory saw %0d accesses where %0d were expected",
                                access_count, exp_access));
        else
        begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

/* verilog.f */
+incdir+hw
hw/isa_pkg.sv
hw/instr_decoder.sv
hw/register_file.sv
hw/exec_unit.sv
hw/pc_unit.sv
hw/cpu_core.sv
tests/cpu_core_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = cpu_core_tb
FILELIST = verilog.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
